// ==== filelist.f ====
design/gmii_pkg.sv
design/frame_pkg.sv
design/gmii_rx_frame.sv
design/frame_fifo.sv
design/gmii_tx_frame.sv
design/gmii_loopback.sv
bench/gmii_loopback_chk.sv
bench/tb_gmii_loopback.sv

// ==== run.sh ====
#!/bin/sh
# Build the GMII loopback testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_gmii_loopback \
    -o sim_tb_gmii_loopback

./obj_dir/sim_tb_gmii_loopback | tee sim.log

grep -qx "Simulation passed" sim.log
echo "run.sh: pass line found in sim.log"

// ==== bench/tb_gmii_loopback.sv ====
// Self-checking testbench for the GMII loopback; random frames go in, payloads are checked coming out
`timescale 1ns/100ps

module tb_gmii_loopback;

    localparam int MAX_LEN       = 64;
    localparam int ADDR_W        = 7;
    localparam int IFG           = gmii_pkg::DEFAULT_IFG_LEN;
    localparam int HDR_LEN       = gmii_pkg::PREAMBLE_LEN + 1;
    localparam int RX_GAP        = 2;
    localparam int BURST_FRAMES  = 16;
    localparam int BYTE_TIMEOUT  = 1000;
    localparam int FRAME_TIMEOUT = 20000;
    localparam int QUIET_CYCLES  = 200;

    logic                 clk;
    logic                 rst;
    logic                 clk_en = 1'b0;
    gmii_pkg::gmii_byte_t gmii_rxd;
    logic                 gmii_rx_dv;
    logic                 gmii_rx_er;
    gmii_pkg::gmii_byte_t gmii_txd;
    logic                 gmii_tx_en;
    logic                 gmii_tx_er;

    integer seed = 32'h669c3eed;
    logic   allow_skip;
    int     tx_frame_cnt;

    // Model of the loopback: payload bytes of all pending frames and one length per frame
    gmii_pkg::gmii_byte_t exp_data[$];
    int                   exp_len[$];

    // Bytes of the frame now on the transmit line
    gmii_pkg::gmii_byte_t line_buf[$];

    gmii_loopback #(
        .MAX_FRAME_LEN(MAX_LEN),
        .FIFO_ADDR_W(ADDR_W),
        .IFG_LEN(IFG)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .clk_en(clk_en),
        .gmii_rxd(gmii_rxd),
        .gmii_rx_dv(gmii_rx_dv),
        .gmii_rx_er(gmii_rx_er),
        .gmii_txd(gmii_txd),
        .gmii_tx_en(gmii_tx_en),
        .gmii_tx_er(gmii_tx_er)
    );

    always #5 clk = ~clk;

    // Enable is high about three cycles in four
    always @(posedge clk) begin
        clk_en <= (($random(seed) & 3) != 0);
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                        $time, name, actual, expected));
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Hold one byte on the receive pins until an enabled edge has taken it
    task automatic drive_rx(input gmii_pkg::gmii_byte_t data, input logic dv, input logic er);
        int waited;
        waited = 0;
        gmii_rxd   <= data;
        gmii_rx_dv <= dv;
        gmii_rx_er <= er;
        @(posedge clk);
        while (!clk_en) begin
            waited++;
            if (waited > BYTE_TIMEOUT) begin
                stop_with_failure("Timeout: clk_en stayed low while a receive byte waited");
            end
            @(posedge clk);
        end
    endtask

    // err_pos below zero means no rx_er; keep puts the payload into the model
    task automatic send_frame(input int len, input int err_pos, input logic keep);
        gmii_pkg::gmii_byte_t b;
        for (int i = 0; i < gmii_pkg::PREAMBLE_LEN; i++) begin
            drive_rx(gmii_pkg::PREAMBLE_BYTE, 1'b1, 1'b0);
        end
        drive_rx(gmii_pkg::SFD_BYTE, 1'b1, 1'b0);
        for (int i = 0; i < len; i++) begin
            b = gmii_pkg::gmii_byte_t'($random(seed));
            if (keep) begin
                exp_data.push_back(b);
            end
            drive_rx(b, 1'b1, (i == err_pos));
        end
        // Length goes in last so the monitor never sees a half-built entry
        if (keep) begin
            exp_len.push_back(len);
        end
        for (int i = 0; i < RX_GAP; i++) begin
            drive_rx(8'h00, 1'b0, 1'b0);
        end
    endtask

    task automatic wait_until_drained();
        int waited;
        waited = 0;
        while (exp_len.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > FRAME_TIMEOUT) begin
                stop_with_failure("Timeout: an expected frame did not come back");
            end
        end
    endtask

    task automatic wait_tx_quiet();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < QUIET_CYCLES) begin
            @(posedge clk);
            waited++;
            quiet = gmii_tx_en ? 0 : quiet + 1;
            if (waited > FRAME_TIMEOUT) begin
                stop_with_failure("Timeout: the transmit side never went quiet after the burst");
            end
        end
    endtask

    function automatic logic frame_matches_head();
        if (exp_len.size() == 0 || exp_len[0] != line_buf.size() - HDR_LEN) begin
            return 1'b0;
        end
        for (int i = 0; i < exp_len[0]; i++) begin
            if (exp_data[i] != line_buf[i + HDR_LEN]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic drop_expected_head();
        for (int i = 0; i < exp_len[0]; i++) begin
            void'(exp_data.pop_front());
        end
        void'(exp_len.pop_front());
    endtask

    task automatic check_tx_frame();
        int plen;
        if (line_buf.size() < HDR_LEN) begin
            stop_with_failure("A transmitted frame was shorter than its preamble and SFD");
        end
        for (int i = 0; i < gmii_pkg::PREAMBLE_LEN; i++) begin
            check_value("gmii_txd preamble", 32'(line_buf[i]), 32'(gmii_pkg::PREAMBLE_BYTE));
        end
        check_value("gmii_txd sfd", 32'(line_buf[HDR_LEN - 1]), 32'(gmii_pkg::SFD_BYTE));
        plen = line_buf.size() - HDR_LEN;
        // Frames dropped for lack of space leave the model whole
        if (allow_skip) begin
            while (exp_len.size() != 0 && !frame_matches_head()) begin
                drop_expected_head();
            end
        end
        if (exp_len.size() == 0) begin
            stop_with_failure("A frame was transmitted that matches no expected frame");
        end
        check_value("gmii_txd payload length", 32'(plen), 32'(exp_len[0]));
        for (int i = 0; i < plen; i++) begin
            check_value("gmii_txd payload", 32'(line_buf[i + HDR_LEN]), 32'(exp_data[i]));
        end
        drop_expected_head();
        tx_frame_cnt++;
    endtask

    // One line byte per enabled cycle
    always @(posedge clk) begin
        if (!rst && clk_en) begin
            check_value("gmii_tx_er", 32'(gmii_tx_er), 32'd0);
            if (gmii_tx_en) begin
                line_buf.push_back(gmii_txd);
            end else if (line_buf.size() != 0) begin
                check_tx_frame();
                line_buf.delete();
            end
        end
    end

    initial begin
        int len;
        int burst_start;
        clk          = 1'b0;
        rst          = 1'b1;
        gmii_rxd     = 8'h00;
        gmii_rx_dv   = 1'b0;
        gmii_rx_er   = 1'b0;
        allow_skip   = 1'b0;
        tx_frame_cnt = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Good frames one at a time
        send_frame(1, -1, 1'b1);
        wait_until_drained();
        repeat (20) begin
            send_frame(1 + rand_below(MAX_LEN), -1, 1'b1);
            wait_until_drained();
        end

        // rx_er on one byte drops the frame, the following one still passes
        repeat (4) begin
            len = 1 + rand_below(MAX_LEN);
            send_frame(len, rand_below(len), 1'b0);
            send_frame(1 + rand_below(MAX_LEN), -1, 1'b1);
            wait_until_drained();
        end

        // Length limit
        send_frame(MAX_LEN + 1, -1, 1'b0);
        send_frame(MAX_LEN, -1, 1'b1);
        wait_until_drained();

        // Back-to-back burst well past the buffer size
        allow_skip  = 1'b1;
        burst_start = tx_frame_cnt;
        repeat (BURST_FRAMES) begin
            send_frame(MAX_LEN / 2 + rand_below(MAX_LEN / 2 + 1), -1, 1'b1);
        end
        wait_tx_quiet();
        while (exp_len.size() != 0) begin
            drop_expected_head();
        end
        allow_skip = 1'b0;
        if (tx_frame_cnt == burst_start) begin
            stop_with_failure("No frame of the burst was transmitted");
        end
        if (tx_frame_cnt - burst_start == BURST_FRAMES) begin
            stop_with_failure("The burst did not overflow the buffer and no frame was dropped");
        end

        // Normal traffic again after the overflow
        repeat (5) begin
            send_frame(1 + rand_below(MAX_LEN), -1, 1'b1);
            wait_until_drained();
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== bench/gmii_loopback_chk.sv ====
// Concurrent assertions on the GMII transmit pins of the loopback, bound into the top level
`timescale 1ns/100ps

module gmii_loopback_chk #(
    parameter int IFG_LEN = gmii_pkg::DEFAULT_IFG_LEN
) (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 clk_en,
    input wire gmii_pkg::gmii_byte_t gmii_txd,
    input wire logic                 gmii_tx_en
);

    // Enabled idle cycles on the line since the last frame
    logic [15:0] idle_cnt;
    logic        seen_frame;

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_cnt   <= '0;
            seen_frame <= 1'b0;
        end else if (clk_en) begin
            if (gmii_tx_en) begin
                idle_cnt   <= '0;
                seen_frame <= 1'b1;
            end else if (idle_cnt != '1) begin
                idle_cnt <= idle_cnt + 16'd1;
            end
        end
    end

    // Line holds its byte and enable through cycles without clk_en
    line_held_when_disabled: assert property (@(posedge clk) disable iff (rst)
        !clk_en |=> ($stable(gmii_tx_en) && $stable(gmii_txd)))
        else $error("gmii_txd or gmii_tx_en changed on a cycle without clk_en");

    // First byte of every frame is a preamble byte
    frame_starts_with_preamble: assert property (@(posedge clk) disable iff (rst)
        $rose(gmii_tx_en) |-> (gmii_txd == gmii_pkg::PREAMBLE_BYTE))
        else $error("gmii_tx_en rose with a byte other than the preamble byte");

    gap_kept: assert property (@(posedge clk) disable iff (rst)
        $rose(gmii_tx_en) |-> (!seen_frame || (idle_cnt >= 16'(IFG_LEN))))
        else $error("inter-frame gap shorter than IFG_LEN enabled cycles");

endmodule

bind gmii_loopback gmii_loopback_chk #(
    .IFG_LEN(IFG_LEN)
) chk0 (
    .clk(clk),
    .rst(rst),
    .clk_en(clk_en),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en)
);

// ==== design/gmii_loopback.sv ====
// Top level of the single-port GMII loopback; received frames are buffered and sent back out
`timescale 1ns/100ps

module gmii_loopback #(
    parameter int MAX_FRAME_LEN = frame_pkg::DEFAULT_MAX_FRAME_LEN,
    parameter int FIFO_ADDR_W = frame_pkg::DEFAULT_FIFO_ADDR_W,
    parameter int IFG_LEN = gmii_pkg::DEFAULT_IFG_LEN
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 clk_en,
    input  wire gmii_pkg::gmii_byte_t gmii_rxd,
    input  wire logic                 gmii_rx_dv,
    input  wire logic                 gmii_rx_er,
    output wire gmii_pkg::gmii_byte_t gmii_txd,
    output wire logic                 gmii_tx_en,
    output wire logic                 gmii_tx_er
);

    // Receive side to buffer
    logic                 wr_valid;
    logic                 wr_last;
    logic                 wr_bad;
    gmii_pkg::gmii_byte_t wr_data;

    // Buffer to transmit side
    logic                 frame_avail;
    logic                 rd_en;
    logic                 rd_last;
    gmii_pkg::gmii_byte_t rd_data;

    gmii_rx_frame #(
        .MAX_FRAME_LEN(MAX_FRAME_LEN)
    ) rx0 (
        .clk(clk),
        .rst(rst),
        .clk_en(clk_en),
        .rxd(gmii_rxd),
        .rx_dv(gmii_rx_dv),
        .rx_er(gmii_rx_er),
        .wr_valid(wr_valid),
        .wr_last(wr_last),
        .wr_bad(wr_bad),
        .wr_data(wr_data)
    );

    frame_fifo #(
        .FIFO_ADDR_W(FIFO_ADDR_W)
    ) fifo0 (
        .clk(clk),
        .rst(rst),
        .wr_valid(wr_valid),
        .wr_last(wr_last),
        .wr_bad(wr_bad),
        .wr_data(wr_data),
        .rd_en(rd_en),
        .frame_avail(frame_avail),
        .rd_last(rd_last),
        .rd_data(rd_data)
    );

    gmii_tx_frame #(
        .IFG_LEN(IFG_LEN)
    ) tx0 (
        .clk(clk),
        .rst(rst),
        .clk_en(clk_en),
        .frame_avail(frame_avail),
        .rd_last(rd_last),
        .rd_data(rd_data),
        .rd_en(rd_en),
        .tx_en(gmii_tx_en),
        .tx_er(gmii_tx_er),
        .txd(gmii_txd)
    );

endmodule

// ==== design/gmii_tx_frame.sv ====
// GMII transmit side of the loopback; sends buffered frames with preamble, SFD and inter-frame gap
`timescale 1ns/100ps

module gmii_tx_frame #(
    parameter int IFG_LEN = gmii_pkg::DEFAULT_IFG_LEN
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 clk_en,
    input  wire logic                 frame_avail,
    input  wire logic                 rd_last,
    input  wire gmii_pkg::gmii_byte_t rd_data,
    output logic                      rd_en,
    output logic                      tx_en,
    output logic                      tx_er,
    output gmii_pkg::gmii_byte_t      txd
);

    localparam int PRE_W = $clog2(gmii_pkg::PREAMBLE_LEN + 1);
    localparam int GAP_W = $clog2(IFG_LEN + 2);

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_PREAMBLE = 3'd1;
    localparam logic [2:0] ST_SFD      = 3'd2;
    localparam logic [2:0] ST_PAYLOAD  = 3'd3;
    localparam logic [2:0] ST_GAP      = 3'd4;

    logic [2:0]       state;
    logic [PRE_W-1:0] pre_cnt;
    logic [GAP_W-1:0] gap_cnt;
    logic             last_sent;
    logic             pre_done;
    logic             load_byte;

    // Final preamble byte on the line
    assign pre_done = (state == ST_PREAMBLE) &&
                      (pre_cnt == PRE_W'(gmii_pkg::PREAMBLE_LEN));

    // Fetched byte moves to txd on this enabled edge
    assign load_byte = (state == ST_SFD) || ((state == ST_PAYLOAD) && !last_sent);

    // Fetch one byte ahead so the payload has no gaps
    assign rd_en = clk_en && (pre_done || (load_byte && !rd_last));

    assign tx_er = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            pre_cnt   <= '0;
            gap_cnt   <= '0;
            last_sent <= 1'b0;
            tx_en     <= 1'b0;
        end else if (clk_en) begin
            case (state)
                ST_IDLE: begin
                    if (frame_avail && (gap_cnt == '0)) begin
                        tx_en   <= 1'b1;
                        pre_cnt <= PRE_W'(1);
                        state   <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (pre_done) begin
                        state <= ST_SFD;
                    end else begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end
                ST_SFD: begin
                    last_sent <= rd_last;
                    state     <= ST_PAYLOAD;
                end
                ST_PAYLOAD: begin
                    if (last_sent) begin
                        tx_en     <= 1'b0;
                        last_sent <= 1'b0;
                        gap_cnt   <= GAP_W'(IFG_LEN);
                        state     <= ST_GAP;
                    end else begin
                        last_sent <= rd_last;
                    end
                end
                ST_GAP: begin
                    if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                    if (gap_cnt <= GAP_W'(1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Line data
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (pre_done) begin
                txd <= gmii_pkg::SFD_BYTE;
            end else if (state == ST_IDLE || state == ST_PREAMBLE) begin
                txd <= gmii_pkg::PREAMBLE_BYTE;
            end else if (load_byte) begin
                txd <= rd_data;
            end
        end
    end

endmodule

// ==== design/frame_fifo.sv ====
// Store-and-forward frame buffer; commits good frames and rolls back bad or overflowing ones
`timescale 1ns/100ps

module frame_fifo #(
    parameter int FIFO_ADDR_W = frame_pkg::DEFAULT_FIFO_ADDR_W
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 wr_valid,
    input  wire logic                 wr_last,
    input  wire logic                 wr_bad,
    input  wire gmii_pkg::gmii_byte_t wr_data,
    input  wire logic                 rd_en,
    output logic                      frame_avail,
    output logic                      rd_last,
    output gmii_pkg::gmii_byte_t      rd_data
);

    localparam int DEPTH = 2 ** FIFO_ADDR_W;

    // Each entry is the last flag above a data byte
    logic [8:0] mem [DEPTH];

    // One extra bit tells full from empty
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] wr_ptr_commit;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic [FIFO_ADDR_W:0] frame_cnt;

    logic full;
    logic drop_frame;
    logic wr_accept;
    logic commit;
    logic rd_fire_q;
    logic release_frame;

    assign full = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                  (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

    assign wr_accept     = wr_valid && !drop_frame && !full;
    assign commit        = wr_accept && wr_last && !wr_bad;
    assign release_frame = rd_fire_q && rd_last;
    assign frame_avail   = (frame_cnt != '0);

    // Write side pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            wr_ptr_commit <= '0;
            drop_frame    <= 1'b0;
        end else if (wr_valid) begin
            if (drop_frame) begin
                // Skip the rest of a frame that overflowed
                if (wr_last) begin
                    drop_frame <= 1'b0;
                end
            end else if (full) begin
                wr_ptr     <= wr_ptr_commit;
                drop_frame <= !wr_last;
            end else if (wr_last && wr_bad) begin
                wr_ptr <= wr_ptr_commit;
            end else if (wr_last) begin
                wr_ptr        <= wr_ptr + 1'b1;
                wr_ptr_commit <= wr_ptr + 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= {wr_last, wr_data};
        end
    end

    // Read side
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr    <= '0;
            rd_fire_q <= 1'b0;
        end else begin
            rd_fire_q <= rd_en;
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            {rd_last, rd_data} <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
        end
    end

    // Committed frames still in the buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
        end else begin
            case ({commit, release_frame})
                2'b10: frame_cnt <= frame_cnt + 1'b1;
                2'b01: frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

endmodule

// ==== design/gmii_rx_frame.sv ====
// GMII receive side of the loopback; strips preamble and SFD and writes payload bytes to the buffer
`timescale 1ns/100ps

module gmii_rx_frame #(
    parameter int MAX_FRAME_LEN = frame_pkg::DEFAULT_MAX_FRAME_LEN
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 clk_en,
    input  wire gmii_pkg::gmii_byte_t rxd,
    input  wire logic                 rx_dv,
    input  wire logic                 rx_er,
    output logic                      wr_valid,
    output logic                      wr_last,
    output logic                      wr_bad,
    output gmii_pkg::gmii_byte_t      wr_data
);

    // Registered GMII inputs
    gmii_pkg::gmii_byte_t rxd_q;
    logic                 dv_q;
    logic                 er_q;

    logic                 in_payload;
    logic                 hold_valid;
    gmii_pkg::gmii_byte_t hold_data;
    logic                 bad;
    frame_pkg::frame_len_t byte_cnt;
    logic                 over_len;

    // Byte about to be taken would go past the limit
    assign over_len = in_payload && (byte_cnt >= frame_pkg::frame_len_t'(MAX_FRAME_LEN));

    // Held byte leaves on every enabled cycle; it is the last one once rx_dv has dropped
    assign wr_valid = clk_en && hold_valid;
    assign wr_last  = wr_valid && !dv_q;
    assign wr_bad   = bad;
    assign wr_data  = hold_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            dv_q       <= 1'b0;
            er_q       <= 1'b0;
            in_payload <= 1'b0;
            hold_valid <= 1'b0;
            bad        <= 1'b0;
            byte_cnt   <= '0;
        end else if (clk_en) begin
            dv_q       <= rx_dv;
            er_q       <= rx_er;
            hold_valid <= 1'b0;
            if (dv_q) begin
                // Error and length flag stays set until the frame ends
                bad <= bad || er_q || over_len;
                if (in_payload) begin
                    hold_valid <= 1'b1;
                    if (byte_cnt != '1) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end else if (rxd_q == gmii_pkg::SFD_BYTE) begin
                    in_payload <= 1'b1;
                end
            end else begin
                // Carrier gone, ready for the next preamble
                in_payload <= 1'b0;
                bad        <= 1'b0;
                byte_cnt   <= '0;
            end
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (clk_en) begin
            rxd_q <= rxd;
            if (dv_q && in_payload) begin
                hold_data <= rxd_q;
            end
        end
    end

endmodule

// ==== design/frame_pkg.sv ====
// Frame length type and frame buffer defaults shared by the loopback RTL and its testbench

package frame_pkg;

    // Largest payload accepted before a frame is marked bad
    localparam int DEFAULT_MAX_FRAME_LEN = 1518;

    // 4096-byte frame buffer
    localparam int DEFAULT_FIFO_ADDR_W = 12;

    // Byte counter for one frame
    typedef logic [15:0] frame_len_t;

endpackage

// ==== design/gmii_pkg.sv ====
// GMII line constants and byte type, referenced by scoped name from the RTL and testbench

package gmii_pkg;

    // One byte on the GMII data lines
    typedef logic [7:0] gmii_byte_t;

    // Preamble and start-of-frame delimiter
    localparam gmii_byte_t PREAMBLE_BYTE = 8'h55;
    localparam gmii_byte_t SFD_BYTE = 8'hD5;

    // Preamble bytes sent ahead of the SFD
    localparam int PREAMBLE_LEN = 7;

    // Idle cycles kept between transmitted frames
    localparam int DEFAULT_IFG_LEN = 12;

endpackage
